/* div_unit.f */
+incdir+rtl
rtl/div_types_pkg.sv
rtl/div_fifo.sv
rtl/div_apb_regs.sv
rtl/div_issue.sv
rtl/div.sv
rtl/div_unit_top.sv
sim/div_unit_tb.sv

/* sim/div_unit_tb.sv */
`timescale 1ns/1ps
`include "div_settings.svh"

module div_unit_tb;
    import div_types_pkg::*;

    localparam int    CLK_PERIOD  = 20;
    localparam int    MAX_OPS     = 200;
    localparam int    OP_CYCLES   = 60;
    localparam int    POLL_LIMIT  = 80;
    localparam int    RETRY_LIMIT = 50;
    localparam word_t MOST_NEG    = word_t'(1) << (`DIV_WIDTH - 1);

    logic      clk;
    logic      rst;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pslverr;

    word_t exp_quot[$]; // Model results in issue order.
    word_t exp_rem[$];
    logic  exp_dbz[$];

    div_unit_top div_unit_top_inst (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(MAX_OPS * OP_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time.");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired.");
    end

    assert property (@(posedge clk) disable iff (rst) pslverr |-> (psel && penable))
    else begin
        $display("pslverr was raised outside an APB access cycle.");
        $display("SOME TESTS FAILED");
        $fatal(1, "Protocol check failed.");
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at the first error.");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopping at the first error.");
        end
    endtask

    // ####################
    // APB transfers
    // ####################

    task automatic apb_write(input apb_addr_t addr, input word_t data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr; // Mid access cycle.
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // ####################
    // Model and sequences
    // ####################

    // Truncating divide whose remainder keeps the dividend's sign.
    function automatic void model_div(input logic sgn, input word_t a, input word_t b,
                                      output word_t q, output word_t r, output logic dbz);
        longint sa;
        longint sb;
        dbz = (b == '0);
        q   = '0;
        r   = '0;
        if (!dbz && sgn) begin
            sa = longint'(signed'(a));
            sb = longint'(signed'(b));
            q  = word_t'(sa / sb); // Wraps to 0x80000000 for MIN / -1.
            r  = word_t'(sa % sb);
        end else if (!dbz) begin
            q = a / b;
            r = a % b;
        end
    endfunction

    task automatic send_cmd(input string name, input logic sgn, input word_t a, input word_t b);
        logic  err;
        int    tries;
        word_t q;
        word_t r;
        logic  dbz;
        apb_write(`DIV_ADDR_DIVIDEND, a, err);
        apb_write(`DIV_ADDR_DIVISOR, b, err);
        tries = 0;
        err   = 1'b1;
        while (err) begin
            if (tries == RETRY_LIMIT) stop_run({"Command queue never accepted ", name});
            apb_write(`DIV_ADDR_CTRL, word_t'(sgn), err); // Retried while the queue is full.
            tries++;
        end
        model_div(sgn, a, b, q, r, dbz);
        exp_quot.push_back(q);
        exp_rem.push_back(r);
        exp_dbz.push_back(dbz);
    endtask

    task automatic wait_status(input string name, input int bit_idx);
        word_t status;
        logic  err;
        int    polls;
        polls  = 0;
        status = '0;
        while (!status[bit_idx]) begin
            if (polls == POLL_LIMIT) stop_run({"STATUS bit never set while waiting on ", name});
            apb_read(`DIV_ADDR_STATUS, status, err);
            polls++;
        end
    endtask

    task automatic check_result(input string name);
        word_t status;
        word_t quot;
        word_t rem;
        logic  err;
        if (exp_quot.size() == 0) stop_run({"No expected result is left for ", name});
        apb_read(`DIV_ADDR_STATUS, status, err);
        check_word({name, " dbz"}, word_t'(exp_dbz.pop_front()), word_t'(status[2]));
        apb_read(`DIV_ADDR_QUOT, quot, err);
        check_word({name, " quotient"}, exp_quot.pop_front(), quot);
        check_word({name, " quotient pslverr"}, '0, word_t'(err));
        apb_read(`DIV_ADDR_REM, rem, err);
        check_word({name, " remainder"}, exp_rem.pop_front(), rem);
        check_word({name, " remainder pslverr"}, '0, word_t'(err));
    endtask

    task automatic run_one(input string name, input logic sgn, input word_t a, input word_t b);
        send_cmd(name, sgn, a, b);
        wait_status(name, 0);
        check_result(name);
    endtask

    initial begin
        word_t data;
        word_t a;
        word_t b;
        logic  err;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(38256));
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        apb_read(`DIV_ADDR_STATUS, data, err);
        check_word("reset status", '0, data);
        check_word("reset pslverr", '0, word_t'(err));
        apb_read(`DIV_ADDR_QUOT, data, err);
        check_word("empty quotient read", '0, data);
        check_word("empty quotient pslverr", 1, word_t'(err));
        apb_read(`DIV_ADDR_REM, data, err);
        check_word("empty remainder read", '0, data);
        check_word("empty remainder pslverr", 1, word_t'(err));

        run_one("unsigned divisor one", 1'b0, 32'hDEAD_BEEF, 32'd1);
        run_one("unsigned small dividend", 1'b0, 32'd5, 32'd9);
        run_one("unsigned all ones", 1'b0, 32'hFFFF_FFFF, 32'h10);
        for (int i = 0; i < 30; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32); // Spread the divisor size.
            run_one("unsigned random", 1'b0, a, b);
        end

        run_one("signed pos by pos", 1'b1, 32'd100, 32'd7);
        run_one("signed neg by pos", 1'b1, -32'sd100, 32'd7);
        run_one("signed pos by neg", 1'b1, 32'd100, -32'sd7);
        run_one("signed neg by neg", 1'b1, -32'sd100, -32'sd7);
        run_one("signed min by minus one", 1'b1, MOST_NEG, 32'hFFFF_FFFF);
        for (int i = 0; i < 30; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            if ($urandom % 2) b = -b;
            run_one("signed random", 1'b1, a, b);
        end

        run_one("unsigned zero divisor", 1'b0, 32'd1234, 32'd0);
        run_one("signed zero divisor", 1'b1, -32'sd5, 32'd0);

        // ####################
        // Queueing and back-pressure
        // ####################

        for (int i = 0; i < 4; i++) send_cmd("queued", 1'(i), $urandom, ($urandom >> 4) | 1);
        for (int i = 0; i < 4; i++) begin
            wait_status("queued", 0);
            check_result("queued");
        end

        // Four results, one stalled in the divider, four queued.
        for (int i = 0; i < 9; i++) send_cmd("backpressure", 1'(i), $urandom, $urandom >> i);
        wait_status("command queue full", 1);
        apb_write(`DIV_ADDR_CTRL, '0, err);
        check_word("full queue pslverr", 1, word_t'(err));
        for (int i = 0; i < 9; i++) begin
            wait_status("backpressure", 0);
            check_result("backpressure");
        end

        send_cmd("reset flush", 1'b0, 32'd77, 32'd3);
        wait_status("reset flush", 0);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        exp_quot.delete();
        exp_rem.delete();
        exp_dbz.delete();
        apb_read(`DIV_ADDR_STATUS, data, err);
        check_word("status after reset", '0, data);
        check_word("pslverr after reset", '0, word_t'(err));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* rtl/div_unit_top.sv */
`timescale 1ns/1ps
`include "div_settings.svh"

module div_unit_top (
    input  logic                     clk,
    input  logic                     rst,
    input  div_types_pkg::apb_addr_t paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  div_types_pkg::word_t     pwdata,
    output div_types_pkg::word_t     prdata,
    output logic                     pslverr
);
    import div_types_pkg::*;

    logic     cmd_push;
    logic     cmd_pop;
    logic     cmd_full;
    logic     cmd_empty;
    div_cmd_t cmd_wr_data;
    div_cmd_t cmd_rd_data;
    logic     res_push;
    logic     res_pop;
    logic     res_full;
    logic     res_empty;
    div_res_t res_wr_data;
    div_res_t res_rd_data;
    logic     div_start;
    logic     div_signed;
    word_t    div_data1;
    word_t    div_data2;
    logic     div_done;
    logic     div_dbz;
    word_t    div_quot;
    word_t    div_rem;

    // ####################
    // Host side
    // ####################

    div_apb_regs regs_inst (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .cmd_push(cmd_push), .cmd_data(cmd_wr_data), .cmd_full(cmd_full),
        .res_pop(res_pop), .res_data(res_rd_data), .res_empty(res_empty)
    );

    div_fifo #(.WIDTH($bits(div_cmd_t)), .DEPTH(`DIV_QUEUE_DEPTH)) cmd_queue (
        .clk(clk), .rst(rst),
        .push(cmd_push), .push_data(cmd_wr_data),
        .pop(cmd_pop), .pop_data(cmd_rd_data),
        .full(cmd_full), .empty(cmd_empty)
    );

    // ####################
    // Divide engine
    // ####################

    div_issue issue_inst (
        .clk(clk), .rst(rst),
        .cmd_empty(cmd_empty), .cmd_data(cmd_rd_data), .cmd_pop(cmd_pop),
        .res_full(res_full), .res_push(res_push), .res_data(res_wr_data),
        .div_start(div_start), .div_signed(div_signed),
        .div_data1(div_data1), .div_data2(div_data2),
        .div_done(div_done), .div_dbz(div_dbz),
        .div_quot(div_quot), .div_rem(div_rem)
    );

    div div_inst (
        .clk(clk), .rst(rst),
        .div_start(div_start), .div_signed(div_signed),
        .div_data1(div_data1), .div_data2(div_data2),
        .div_done(div_done), .div_dbz(div_dbz),
        .div_quot(div_quot), .div_rem(div_rem)
    );

    div_fifo #(.WIDTH($bits(div_res_t)), .DEPTH(`DIV_QUEUE_DEPTH)) res_queue (
        .clk(clk), .rst(rst),
        .push(res_push), .push_data(res_wr_data),
        .pop(res_pop), .pop_data(res_rd_data),
        .full(res_full), .empty(res_empty)
    );

endmodule

/* rtl/div.sv */
`timescale 1ns/1ps
`include "div_settings.svh"

module div (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 div_start,
    input  logic                 div_signed,
    input  div_types_pkg::word_t div_data1,
    input  div_types_pkg::word_t div_data2,
    output logic                 div_done,
    output logic                 div_dbz,
    output div_types_pkg::word_t div_quot,
    output div_types_pkg::word_t div_rem
);
    import div_types_pkg::*;

    localparam int W = `DIV_WIDTH;

    div_state_t         state;
    logic [$clog2(W):0] cnt;
    word_t              rem_r;     // Partial remainder.
    word_t              quot_r;    // Dividend out, quotient in.
    word_t              divisor_r;
    logic               neg_quot;
    logic               neg_rem;
    word_t              mag1;
    word_t              mag2;
    logic [W:0]         shifted;
    logic [W+1:0]       diff;

    // Operand magnitudes.
    assign mag1 = (div_signed && div_data1[W-1]) ? ~div_data1 + 1'b1 : div_data1;
    assign mag2 = (div_signed && div_data2[W-1]) ? ~div_data2 + 1'b1 : div_data2;

    // One restoring step; diff[W+1] is the borrow.
    assign shifted = {rem_r, quot_r[W-1]};
    assign diff    = {1'b0, shifted} - {2'b00, divisor_r};

    assign div_quot = quot_r;
    assign div_rem  = rem_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= div_free;
            cnt      <= '0;
            div_done <= 1'b0;
            div_dbz  <= 1'b0;
        end else begin
            case (state)
                div_free: begin
                    div_done <= 1'b0;
                    if (div_start) begin
                        if (div_data2 == '0) begin
                            state   <= div_by_zero;
                            div_dbz <= 1'b1;
                        end else begin
                            state     <= div_on;
                            cnt       <= '0;
                            div_dbz   <= 1'b0;
                            rem_r     <= '0;
                            quot_r    <= mag1;
                            divisor_r <= mag2;
                            neg_quot  <= div_signed && (div_data1[W-1] ^ div_data2[W-1]);
                            neg_rem   <= div_signed && div_data1[W-1];
                        end
                    end
                end
                div_by_zero: begin
                    quot_r <= '0;
                    rem_r  <= '0;
                    state  <= div_end;
                end
                div_on: begin
                    if (cnt != W) begin
                        if (diff[W+1]) begin
                            rem_r  <= shifted[W-1:0]; // Restore.
                            quot_r <= {quot_r[W-2:0], 1'b0};
                        end else begin
                            rem_r  <= diff[W-1:0];
                            quot_r <= {quot_r[W-2:0], 1'b1};
                        end
                        cnt <= cnt + 1'b1;
                    end else begin
                        // Sign fix-up.
                        if (neg_quot) begin
                            quot_r <= ~quot_r + 1'b1;
                        end
                        if (neg_rem) begin
                            rem_r <= ~rem_r + 1'b1; // Remainder follows dividend.
                        end
                        cnt   <= '0;
                        state <= div_end;
                    end
                end
                div_end: begin
                    if (!div_start) begin
                        state    <= div_free;
                        div_done <= 1'b0;
                    end else begin
                        div_done <= 1'b1; // Held until start drops.
                    end
                end
                default: state <= div_free;
            endcase
        end
    end

endmodule

/* rtl/div_issue.sv */
`timescale 1ns/1ps
`include "div_settings.svh"

module div_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_empty,
    input  div_types_pkg::div_cmd_t cmd_data,
    output logic                    cmd_pop,
    input  logic                    res_full,
    output logic                    res_push,
    output div_types_pkg::div_res_t res_data,
    output logic                    div_start,
    output logic                    div_signed,
    output div_types_pkg::word_t    div_data1,
    output div_types_pkg::word_t    div_data2,
    input  logic                    div_done,
    input  logic                    div_dbz,
    input  div_types_pkg::word_t    div_quot,
    input  div_types_pkg::word_t    div_rem
);
    import div_types_pkg::*;

    localparam int W = `DIV_WIDTH;

    typedef enum logic {
        iss_idle,
        iss_busy
    } iss_state_t;

    iss_state_t state;

    assign cmd_pop  = (state == iss_idle) && !cmd_empty;
    assign res_push = (state == iss_busy) && div_done && !res_full; // Stall while full.
    assign res_data = {div_dbz, div_quot, div_rem};

    // Operands stay put for the whole handshake.
    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            div_signed <= cmd_data[2*W];
            div_data1  <= cmd_data[2*W-1:W];
            div_data2  <= cmd_data[W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= iss_idle;
            div_start <= 1'b0;
        end else begin
            case (state)
                iss_idle: begin
                    if (cmd_pop) begin
                        state     <= iss_busy;
                        div_start <= 1'b1;
                    end
                end
                iss_busy: begin
                    if (res_push) begin
                        state     <= iss_idle;
                        div_start <= 1'b0; // Releases the divider.
                    end
                end
                default: state <= iss_idle;
            endcase
        end
    end

endmodule

/* rtl/div_apb_regs.sv */
`timescale 1ns/1ps
`include "div_settings.svh"

module div_apb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  div_types_pkg::apb_addr_t paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  div_types_pkg::word_t     pwdata,
    output div_types_pkg::word_t     prdata,
    output logic                     pslverr,
    output logic                     cmd_push,
    output div_types_pkg::div_cmd_t  cmd_data,
    input  logic                     cmd_full,
    output logic                     res_pop,
    input  div_types_pkg::div_res_t  res_data,
    input  logic                     res_empty
);
    import div_types_pkg::*;

    localparam int W = `DIV_WIDTH;

    logic  wr_access;
    logic  rd_access;
    logic  ctrl_wr;
    logic  result_rd;
    word_t dividend_r;
    word_t divisor_r;
    word_t head_quot;
    word_t head_rem;
    logic  head_dbz;

    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && penable && !pwrite;

    assign ctrl_wr   = wr_access && (paddr == `DIV_ADDR_CTRL);
    assign result_rd = rd_access && ((paddr == `DIV_ADDR_QUOT) || (paddr == `DIV_ADDR_REM));

    assign head_dbz  = res_data[2*W];
    assign head_quot = res_data[2*W-1:W];
    assign head_rem  = res_data[W-1:0];

    // ####################
    // Queue strobes
    // ####################

    assign cmd_push = ctrl_wr && !cmd_full;
    assign cmd_data = {pwdata[0], dividend_r, divisor_r}; // Bit 0 selects signed.
    assign res_pop  = rd_access && (paddr == `DIV_ADDR_REM) && !res_empty;

    // Dropped CTRL write or read of an empty result queue.
    assign pslverr = (ctrl_wr && cmd_full) || (result_rd && res_empty);

    // ####################
    // Operand registers
    // ####################

    always_ff @(posedge clk) begin
        if (rst) begin
            dividend_r <= '0;
            divisor_r  <= '0;
        end else if (wr_access) begin
            case (paddr)
                `DIV_ADDR_DIVIDEND: dividend_r <= pwdata;
                `DIV_ADDR_DIVISOR:  divisor_r  <= pwdata;
                default: begin
                end
            endcase
        end
    end

    // ####################
    // Read mux
    // ####################

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                `DIV_ADDR_DIVIDEND: prdata = dividend_r;
                `DIV_ADDR_DIVISOR:  prdata = divisor_r;
                `DIV_ADDR_STATUS: begin
                    prdata[0] = !res_empty;
                    prdata[1] = cmd_full;
                    prdata[2] = head_dbz && !res_empty; // Head is stale when empty.
                end
                `DIV_ADDR_QUOT: begin
                    if (!res_empty) begin
                        prdata = head_quot;
                    end
                end
                `DIV_ADDR_REM: begin
                    if (!res_empty) begin
                        prdata = head_rem;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* rtl/div_fifo.sv */
`timescale 1ns/1ps

module div_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr]; // Head is visible without a pop.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

endmodule

/* rtl/div_types_pkg.sv */
`include "div_settings.svh"

package div_types_pkg;

    typedef logic [`DIV_WIDTH-1:0] word_t;
    typedef logic [7:0] apb_addr_t;

    // {signed, dividend, divisor}.
    typedef logic [2*`DIV_WIDTH:0] div_cmd_t;

    // {dbz, quotient, remainder}.
    typedef logic [2*`DIV_WIDTH:0] div_res_t;

    typedef enum logic [1:0] {
        div_free,
        div_by_zero,
        div_on,
        div_end
    } div_state_t;

endpackage

/* rtl/div_settings.svh */
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// ####################
// Datapath
// ####################

`define DIV_WIDTH 32
`define DIV_QUEUE_DEPTH 4

// ####################
// APB register map
// ####################

`define DIV_ADDR_DIVIDEND 8'h00
`define DIV_ADDR_DIVISOR  8'h04
`define DIV_ADDR_CTRL     8'h08 // Write pushes a command.
`define DIV_ADDR_STATUS   8'h0C
`define DIV_ADDR_QUOT     8'h10
`define DIV_ADDR_REM      8'h14 // Read pops the result.

`endif
